// ==== ieuCfgPkg.sv ====
// Data-path widths are fixed for RV32I; only the register count varies, set at the top level
`default_nettype none

//////////////////////////////////////////////////
// Widths and vector types of the integer datapath
//////////////////////////////////////////////////

package ieuCfgPkg;

  // Machine word, RV32I only
  localparam int xlenW = 32;

  // Register index, wide enough for x0..x31
  localparam int regAddrW = 5;

  // Operands, results and program counters
  typedef logic [xlenW-1:0] xlenT;

  // Register index as it sits in the instruction
  typedef logic [regAddrW-1:0] regIdxT;

  // Raw instruction word, always 32 bits even with compressed code absent
  typedef logic [31:0] instrT;

endpackage

`default_nettype wire

// ==== ieuOpPkg.sv ====
// Encodings cover RV32I integer ops, LUI, AUIPC, jumps and branches; no load, store or system opcodes
`default_nettype none

//////////////////////////////////////////////////
// Instruction fields and internal control codes
//////////////////////////////////////////////////

package ieuOpPkg;

  // Major opcodes, instrD[6:0]
  typedef enum logic [6:0] {
    opOp     = 7'b0110011,
    opOpImm  = 7'b0010011,
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opBranch = 7'b1100011
  } opcodeE;

  // Branch conditions, funct3 of BRANCH
  typedef enum logic [2:0] {
    brEq  = 3'b000,
    brNe  = 3'b001,
    brLt  = 3'b100,
    brGe  = 3'b101,
    brLtu = 3'b110,
    brGeu = 3'b111
  } brFunct3E;

  // ALU operations
  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor,
    aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluPassB
  } aluOpE;

  // Immediate layouts
  typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immFmtE;

  // Operand source in Execute
  typedef enum logic [1:0] {fwdReg = 2'b00, fwdWb = 2'b01, fwdMem = 2'b10} fwdSelE;

  // Execute result source
  typedef enum logic {resAlu, resLink} resultSrcE;

endpackage

`default_nettype wire

// ==== regFile.sv ====
// Reads are combinational with write-through; indices at or above numRegs read as zero
`timescale 1ns/1ps
`default_nettype none

module regFile #(
  parameter int numRegs = 32
) (
  input  logic              clk,
  input  logic              arstN,
  input  logic              we,
  input  ieuCfgPkg::regIdxT ra1,
  input  ieuCfgPkg::regIdxT ra2,
  input  ieuCfgPkg::regIdxT wa,
  input  ieuCfgPkg::xlenT   wd,
  output ieuCfgPkg::xlenT   rd1,
  output ieuCfgPkg::xlenT   rd2
);
  import ieuCfgPkg::*;

  xlenT regs [numRegs];

  // x0 never takes a write
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != '0 && int'(wa) < numRegs) begin
      regs[wa] <= wd;
    end
  end

  // Bypass so Decode sees the Writeback value in the same cycle
  assign rd1 = (ra1 == '0 || int'(ra1) >= numRegs) ? '0 :
               (we && wa == ra1) ? wd : regs[ra1];
  assign rd2 = (ra2 == '0 || int'(ra2) >= numRegs) ? '0 :
               (we && wa == ra2) ? wd : regs[ra2];

  // RV32E builds must never see an upper register index retire
  assert property (@(posedge clk) disable iff (!arstN) we |-> int'(wa) < numRegs);

endmodule

`default_nettype wire

// ==== immExtend.sv ====
// Purely combinational; the S format is kept for completeness though stores are not decoded
`timescale 1ns/1ps
`default_nettype none

module immExtend (
  input  logic [31:7]      instrBits,
  input  ieuOpPkg::immFmtE immFmt,
  output ieuCfgPkg::xlenT  immOut
);
  import ieuOpPkg::*;

  always_comb begin
    case (immFmt)
      // ADDI, JALR and shifts
      immI: immOut = {{20{instrBits[31]}}, instrBits[31:20]};
      // Store offset
      immS: immOut = {{20{instrBits[31]}}, instrBits[31:25], instrBits[11:7]};
      // Branch offset, always even
      immB: immOut = {{20{instrBits[31]}}, instrBits[7], instrBits[30:25],
                      instrBits[11:8], 1'b0};
      // Upper 20 bits for LUI and AUIPC
      immU: immOut = {instrBits[31:12], 12'b0};
      // JAL offset
      immJ: immOut = {{12{instrBits[31]}}, instrBits[19:12], instrBits[20],
                      instrBits[30:21], 1'b0};
      default: immOut = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== intAlu.sv ====
// Shift amount is srcB[4:0]; sum is always srcA + srcB regardless of the selected operation
`timescale 1ns/1ps
`default_nettype none

module intAlu (
  input  ieuCfgPkg::xlenT  srcA,
  input  ieuCfgPkg::xlenT  srcB,
  input  ieuOpPkg::aluOpE  aluOp,
  output ieuCfgPkg::xlenT  result,
  output ieuCfgPkg::xlenT  sum
);
  import ieuCfgPkg::*;
  import ieuOpPkg::*;

  logic [4:0] shamt;
  logic       ltSigned;
  logic       ltUnsigned;

  assign shamt = srcB[4:0];

  // Address adder, feeds branch and jump targets
  assign sum = srcA + srcB;

  assign ltSigned   = $signed(srcA) < $signed(srcB);
  assign ltUnsigned = srcA < srcB;

  //////////////////////////////////////////////////
  // Operation select
  //////////////////////////////////////////////////

  always_comb begin
    case (aluOp)
      aluAdd:   result = sum;
      aluSub:   result = srcA - srcB;
      aluAnd:   result = srcA & srcB;
      aluOr:    result = srcA | srcB;
      aluXor:   result = srcA ^ srcB;
      aluSlt:   result = {{(xlenW-1){1'b0}}, ltSigned};
      aluSltu:  result = {{(xlenW-1){1'b0}}, ltUnsigned};
      aluSll:   result = srcA << shamt;
      aluSrl:   result = srcA >> shamt;
      // Arithmetic shift keeps the sign
      aluSra:   result = xlenT'($signed(srcA) >>> shamt);
      // LUI passes the immediate through
      aluPassB: result = srcB;
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== ieuController.sv ====
// Unknown opcodes decode as bubbles; only register-writing instructions raise wbValid
`timescale 1ns/1ps
`default_nettype none

module ieuController (
  input  logic                clk,
  input  logic                arstN,
  input  ieuCfgPkg::instrT    instrD,
  input  logic                instrValid,
  input  logic                stall,
  input  logic                flushE,
  input  logic [1:0]          branchFlagsE,
  output ieuOpPkg::immFmtE    immFmtD,
  output ieuOpPkg::aluOpE     aluOpE,
  output logic                aluSrcAE,
  output logic                aluSrcBE,
  output ieuOpPkg::resultSrcE resultSrcE,
  output logic                jalrE,
  output logic                takenE,
  output logic                regWriteM,
  output logic                regWriteW,
  output logic                wbValid
);
  import ieuOpPkg::*;

  ieuOpPkg::aluOpE     aluOpD;
  ieuOpPkg::resultSrcE resultSrcD;
  ieuOpPkg::aluOpE     aluFromF3;
  brFunct3E            funct3E;
  logic legalD, validD, regWriteD, aluSrcAD, aluSrcBD, jumpD, jalrD, branchD;
  logic validE, regWriteE, jumpE, branchE, condE;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  // Integer op from funct3, funct7[5] picks SUB and SRA
  always_comb begin
    case (instrD[14:12])
      3'b000:  aluFromF3 = (instrD[6:0] == opOp && instrD[30]) ? aluSub : aluAdd;
      3'b001:  aluFromF3 = aluSll;
      3'b010:  aluFromF3 = aluSlt;
      3'b011:  aluFromF3 = aluSltu;
      3'b100:  aluFromF3 = aluXor;
      3'b101:  aluFromF3 = instrD[30] ? aluSra : aluSrl;
      3'b110:  aluFromF3 = aluOr;
      default: aluFromF3 = aluAnd;
    endcase
  end

  always_comb begin
    legalD     = 1'b1;
    regWriteD  = 1'b0;
    immFmtD    = immI;
    aluOpD     = aluAdd;
    aluSrcAD   = 1'b0;
    aluSrcBD   = 1'b0;
    resultSrcD = resAlu;
    jumpD      = 1'b0;
    jalrD      = 1'b0;
    branchD    = 1'b0;
    case (opcodeE'(instrD[6:0]))
      opOp: begin
        regWriteD = 1'b1;
        aluOpD    = aluFromF3;
      end
      opOpImm: begin
        regWriteD = 1'b1;
        aluSrcBD  = 1'b1;
        aluOpD    = aluFromF3;
      end
      opLui: begin
        regWriteD = 1'b1;
        immFmtD   = immU;
        aluSrcBD  = 1'b1;
        aluOpD    = aluPassB;
      end
      // PC + upper immediate through the ALU adder
      opAuipc: begin
        regWriteD = 1'b1;
        immFmtD   = immU;
        aluSrcAD  = 1'b1;
        aluSrcBD  = 1'b1;
      end
      opJal: begin
        regWriteD  = 1'b1;
        immFmtD    = immJ;
        aluSrcAD   = 1'b1;
        aluSrcBD   = 1'b1;
        resultSrcD = resLink;
        jumpD      = 1'b1;
      end
      // Target from rs1, so srcA stays on the register
      opJalr: begin
        regWriteD  = 1'b1;
        aluSrcBD   = 1'b1;
        resultSrcD = resLink;
        jumpD      = 1'b1;
        jalrD      = 1'b1;
      end
      // The ALU op tells the comparator signed or unsigned
      opBranch: begin
        immFmtD  = immB;
        aluSrcAD = 1'b1;
        aluSrcBD = 1'b1;
        branchD  = 1'b1;
        aluOpD   = instrD[13] ? aluSltu : aluSlt;
      end
      default: legalD = 1'b0;
    endcase
  end

  assign validD = instrValid & legalD;

  //////////////////////////////////////////////////
  // Stage registers, stall holds, flush kills Execute
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validE     <= 1'b0;
      regWriteE  <= 1'b0;
      aluOpE     <= aluAdd;
      aluSrcAE   <= 1'b0;
      aluSrcBE   <= 1'b0;
      resultSrcE <= resAlu;
      jumpE      <= 1'b0;
      jalrE      <= 1'b0;
      branchE    <= 1'b0;
      funct3E    <= brEq;
      regWriteM  <= 1'b0;
      regWriteW  <= 1'b0;
    end else if (!stall) begin
      validE     <= validD & ~flushE;
      regWriteE  <= validD & regWriteD & ~flushE;
      aluOpE     <= aluOpD;
      aluSrcAE   <= aluSrcAD;
      aluSrcBE   <= aluSrcBD;
      resultSrcE <= resultSrcD;
      jumpE      <= jumpD;
      jalrE      <= jalrD;
      branchE    <= branchD;
      funct3E    <= brFunct3E'(instrD[14:12]);
      regWriteM  <= regWriteE;
      regWriteW  <= regWriteM;
    end
  end

  // Flags are {equal, less-than}
  always_comb begin
    case (funct3E)
      brEq:          condE = branchFlagsE[1];
      brNe:          condE = ~branchFlagsE[1];
      brLt, brLtu:   condE = branchFlagsE[0];
      brGe, brGeu:   condE = ~branchFlagsE[0];
      default:       condE = 1'b0;
    endcase
  end

  assign takenE = validE & (jumpE | (branchE & condE));

  // Held Writeback reports once, on the unstalled cycle
  assign wbValid = regWriteW & ~stall;

  assert property (@(posedge clk) disable iff (!arstN) validE |-> !$isunknown(aluOpE));

endmodule

`default_nettype wire

// ==== hazardUnit.sv ====
// No load-use stall exists since loads are absent; Memory wins over Writeback on a double match
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
  input  ieuCfgPkg::regIdxT rs1E,
  input  ieuCfgPkg::regIdxT rs2E,
  input  ieuCfgPkg::regIdxT rdM,
  input  ieuCfgPkg::regIdxT rdW,
  input  logic              regWriteM,
  input  logic              regWriteW,
  input  logic              takenE,
  output ieuOpPkg::fwdSelE  fwdSelA,
  output ieuOpPkg::fwdSelE  fwdSelB,
  output logic              flushE
);
  import ieuCfgPkg::*;
  import ieuOpPkg::*;

  // Youngest producer wins and x0 is never a source
  function automatic fwdSelE pickSrc(input regIdxT rs);
    fwdSelE sel;
    if (rs != '0 && regWriteM && rdM == rs) begin
      sel = fwdMem;
    end else if (rs != '0 && regWriteW && rdW == rs) begin
      sel = fwdWb;
    end else begin
      sel = fwdReg;
    end
    return sel;
  endfunction

  assign fwdSelA = pickSrc(rs1E);
  assign fwdSelB = pickSrc(rs2E);

  // Wrong-path slot sits in Decode while the branch resolves
  assign flushE = takenE;

endmodule

`default_nettype wire

// ==== ieuDatapath.sv ====
// Payload registers power up unknown; wbRd, wbData and redirectTarget only mean something while the matching valid is high
`timescale 1ns/1ps
`default_nettype none

module ieuDatapath #(
  parameter int numRegs = 32
) (
  input  logic                clk,
  input  logic                arstN,
  input  ieuCfgPkg::instrT    instrD,
  input  ieuCfgPkg::xlenT     pcD,
  input  logic                stall,
  input  logic                flushE,
  input  ieuOpPkg::immFmtE    immFmtD,
  input  ieuOpPkg::aluOpE     aluOpE,
  input  logic                aluSrcAE,
  input  logic                aluSrcBE,
  input  ieuOpPkg::resultSrcE resultSrcE,
  input  logic                jalrE,
  input  logic                regWriteW,
  input  ieuOpPkg::fwdSelE    fwdSelA,
  input  ieuOpPkg::fwdSelE    fwdSelB,
  output logic [1:0]          branchFlagsE,
  output ieuCfgPkg::xlenT     redirectTarget,
  output ieuCfgPkg::regIdxT   rs1E,
  output ieuCfgPkg::regIdxT   rs2E,
  output ieuCfgPkg::regIdxT   rdM,
  output ieuCfgPkg::regIdxT   rdW,
  output ieuCfgPkg::regIdxT   wbRd,
  output ieuCfgPkg::xlenT     wbData
);
  import ieuCfgPkg::*;
  import ieuOpPkg::*;

  // Decode
  regIdxT rs1D, rs2D, rdD;
  xlenT   rd1D, rd2D, immD, linkD;
  // Execute
  regIdxT rdE;
  xlenT   rd1E, rd2E, immE, pcE, linkE;
  xlenT   fwdAE, fwdBE, srcAE, srcBE, aluResultE, sumE, resultE;
  logic   eqE, ltE;
  // Memory and Writeback
  xlenT   resultM, resultW;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  assign rs1D  = instrD[19:15];
  assign rs2D  = instrD[24:20];
  assign rdD   = instrD[11:7];
  assign linkD = pcD + 32'd4;

  // No write lands while Writeback is held
  regFile #(.numRegs(numRegs)) u_regFile (
    .clk, .arstN, .we(regWriteW & ~stall),
    .ra1(rs1D), .ra2(rs2D), .wa(rdW), .wd(resultW),
    .rd1(rd1D), .rd2(rd2D)
  );

  immExtend u_immExtend (.instrBits(instrD[31:7]), .immFmt(immFmtD), .immOut(immD));

  //////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////

  // A flushed slot keeps junk here that the cleared valid bit hides
  always_ff @(posedge clk) begin
    if (!stall) begin
      rd1E  <= rd1D;
      rd2E  <= rd2D;
      immE  <= immD;
      pcE   <= pcD;
      linkE <= linkD;
      rs1E  <= rs1D;
      rs2E  <= rs2D;
      rdE   <= rdD;
    end
  end

  always_comb begin
    case (fwdSelA)
      fwdMem:  fwdAE = resultM;
      fwdWb:   fwdAE = resultW;
      default: fwdAE = rd1E;
    endcase
    case (fwdSelB)
      fwdMem:  fwdBE = resultM;
      fwdWb:   fwdBE = resultW;
      default: fwdBE = rd2E;
    endcase
  end

  // Branch compare is unsigned only for BLTU and BGEU
  assign eqE = fwdAE == fwdBE;
  assign ltE = (aluOpE == aluSltu) ? (fwdAE < fwdBE) : ($signed(fwdAE) < $signed(fwdBE));
  assign branchFlagsE = {eqE, ltE};

  assign srcAE = aluSrcAE ? pcE : fwdAE;
  assign srcBE = aluSrcBE ? immE : fwdBE;

  intAlu u_intAlu (
    .srcA(srcAE), .srcB(srcBE), .aluOp(aluOpE), .result(aluResultE), .sum(sumE)
  );

  // JALR drops bit 0 of rs1 + imm
  assign redirectTarget = jalrE ? {sumE[xlenW-1:1], 1'b0} : sumE;

  assign resultE = (resultSrcE == resLink) ? linkE : aluResultE;

  //////////////////////////////////////////////////
  // Memory and Writeback
  //////////////////////////////////////////////////

  // flushE only reaches the control bits of Execute
  always_ff @(posedge clk) begin
    if (!stall) begin
      resultM <= resultE;
      rdM     <= rdE;
      resultW <= resultM;
      rdW     <= rdM;
    end
  end

  assign wbRd   = rdW;
  assign wbData = resultW;

  // A taken branch or jump leaves with a known target
  assert property (@(posedge clk) disable iff (!arstN)
    flushE |-> !$isunknown(redirectTarget));

endmodule

`default_nettype wire

// ==== intExecUnit.sv ====
// No fetch; the caller supplies instrD with pcD and must follow redirect itself
`timescale 1ns/1ps
`default_nettype none

module intExecUnit #(
  parameter int numRegs = 32
) (
  input  logic              clk,
  input  logic              arstN,
  input  ieuCfgPkg::instrT  instrD,
  input  ieuCfgPkg::xlenT   pcD,
  input  logic              instrValid,
  input  logic              stall,
  output logic              redirect,
  output ieuCfgPkg::xlenT   redirectTarget,
  output logic              wbValid,
  output ieuCfgPkg::regIdxT wbRd,
  output ieuCfgPkg::xlenT   wbData
);
  import ieuCfgPkg::*;
  import ieuOpPkg::*;

  ieuOpPkg::immFmtE    immFmtD;
  ieuOpPkg::aluOpE     aluOpE;
  ieuOpPkg::resultSrcE resultSrcE;
  fwdSelE              fwdSelA, fwdSelB;
  regIdxT              rs1E, rs2E, rdM, rdW;
  logic [1:0]          branchFlagsE;
  logic aluSrcAE, aluSrcBE, jalrE, flushE, regWriteM, regWriteW;

  // Taken decision leaves as redirect
  ieuController u_ieuController (
    .clk, .arstN, .instrD, .instrValid, .stall, .flushE, .branchFlagsE,
    .immFmtD, .aluOpE, .aluSrcAE, .aluSrcBE, .resultSrcE, .jalrE,
    .takenE(redirect), .regWriteM, .regWriteW, .wbValid
  );

  ieuDatapath #(.numRegs(numRegs)) u_ieuDatapath (
    .clk, .arstN, .instrD, .pcD, .stall, .flushE, .immFmtD, .aluOpE,
    .aluSrcAE, .aluSrcBE, .resultSrcE, .jalrE, .regWriteW, .fwdSelA, .fwdSelB,
    .branchFlagsE, .redirectTarget, .rs1E, .rs2E, .rdM, .rdW, .wbRd, .wbData
  );

  hazardUnit u_hazardUnit (
    .rs1E, .rs2E, .rdM, .rdW, .regWriteM, .regWriteW, .takenE(redirect),
    .fwdSelA, .fwdSelB, .flushE
  );

endmodule

`default_nettype wire

// ==== ieuTb.sv ====
// Random program over x0..x7 only; the testbench acts as fetch and follows redirect itself
`timescale 1ns/1ps
`default_nettype none

module ieuTb;
  import ieuCfgPkg::*;

  localparam int clkPeriod = 8;
  localparam int numSteps = 600;
  localparam logic [31:0] lfsrSeed = 32'h96ba_7c6f;
  localparam logic [31:0] lfsrTaps = 32'h8020_0003;

  logic   clk;
  logic   arstN;
  instrT  instrD;
  xlenT   pcD;
  logic   instrValid;
  logic   stall;
  logic   redirect;
  xlenT   redirectTarget;
  logic   wbValid;
  regIdxT wbRd;
  xlenT   wbData;

  // Reference model state
  logic [31:0] lfsr;
  logic [31:0] regModel [32];
  logic [31:0] pcModel;
  logic [31:0] pendingPc;
  logic        killPending;
  logic        lastStall;
  logic        lastTaken;
  logic [31:0] lastTarget;
  // Expected Execute outputs and the retirement under check
  logic        expRedirect;
  logic [31:0] expTarget;
  logic [36:0] retireQ [$];
  logic [36:0] expWb;
  logic        haveExp;
  int          sinceReset;
  int          retired;

  intExecUnit u_intExecUnit (
    .clk, .arstN, .instrD, .pcD, .instrValid, .stall,
    .redirect, .redirectTarget, .wbValid, .wbRd, .wbData
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic stopWithFailure(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string sig, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    stopWithFailure($sformatf("[ERROR] %0t %s expected %h actual %h",
                              $time, sig, expVal, actVal));
  endtask

  // Galois LFSR stepping once per bit taken
  function automatic logic [31:0] lfsrBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsrTaps) : (lfsr >> 1);
    end
    return v;
  endfunction

  // RV32I integer result where alt selects SUB or SRA
  function automatic logic [31:0] expectAlu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0:    r = alt ? a - b : a + b;
      3'd1:    r = a << b[4:0];
      3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    r = (a < b) ? 32'd1 : 32'd0;
      3'd4:    r = a ^ b;
      3'd5:    r = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // Random instruction plus its architectural effect at this PC
  task automatic pickInstr(input logic [31:0] pc, output logic [31:0] instr,
                           output logic writes, output logic [4:0] rd,
                           output logic [31:0] data, output logic taken,
                           output logic [31:0] target);
    logic [2:0]  kind;
    logic [2:0]  f3;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [31:0] a;
    logic [31:0] b;
    logic        alt;
    kind   = 3'(lfsrBits(3));
    f3     = 3'(lfsrBits(3));
    rd     = 5'(lfsrBits(3));
    rs1    = 5'(lfsrBits(3));
    rs2    = 5'(lfsrBits(3));
    alt    = 1'(lfsrBits(1));
    imm12  = 12'(lfsrBits(12));
    imm20  = 20'(lfsrBits(20));
    a      = regModel[rs1];
    b      = regModel[rs2];
    writes = 1'b1;
    taken  = 1'b0;
    target = '0;
    case (kind)
      // Register-register
      3'd0, 3'd1: begin
        alt   = alt & (f3 == 3'd0 || f3 == 3'd5);
        instr = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
        data  = expectAlu(f3, alt, a, b);
      end
      // Register-immediate where shifts keep a legal upper field
      3'd2, 3'd3: begin
        alt = alt & (f3 == 3'd5);
        if (f3 == 3'd1 || f3 == 3'd5) begin
          imm12[11:5] = {1'b0, alt, 5'b0};
        end
        instr = {imm12, rs1, f3, rd, 7'b0010011};
        data  = expectAlu(f3, alt, a, {{20{imm12[11]}}, imm12});
      end
      // LUI or AUIPC
      3'd4: begin
        instr = {imm20, rd, alt ? 7'b0010111 : 7'b0110111};
        data  = alt ? pc + {imm20, 12'b0} : {imm20, 12'b0};
      end
      // funct3 010 and 011 fold onto 100 and 101
      3'd5: begin
        if (f3[2:1] == 2'b01) begin
          f3 = f3 ^ 3'b110;
        end
        instr  = {imm12[11], imm12[9:4], rs2, rs1, f3, imm12[3:0], imm12[10], 7'b1100011};
        target = pc + {{19{imm12[11]}}, imm12, 1'b0};
        writes = 1'b0;
        data   = '0;
        case (f3)
          3'd0:    taken = (a == b);
          3'd1:    taken = (a != b);
          3'd4:    taken = ($signed(a) < $signed(b));
          3'd5:    taken = ($signed(a) >= $signed(b));
          3'd6:    taken = (a < b);
          default: taken = (a >= b);
        endcase
      end
      3'd6: begin
        instr  = {imm20[19], imm20[9:0], imm20[10], imm20[18:11], rd, 7'b1101111};
        target = pc + {{11{imm20[19]}}, imm20, 1'b0};
        data   = pc + 32'd4;
        taken  = 1'b1;
      end
      // JALR target drops bit 0
      default: begin
        instr  = {imm12, rs1, 3'b000, rd, 7'b1100111};
        target = (a + {{20{imm12[11]}}, imm12}) & 32'hffff_fffe;
        data   = pc + 32'd4;
        taken  = 1'b1;
      end
    endcase
  endtask

  // One rising edge of stimulus; a stalled slot keeps the inputs as they are
  task automatic issueSlot(input logic stallBit, input logic validBit);
    logic [31:0] instr;
    logic [31:0] data;
    logic [31:0] target;
    logic [4:0]  rd;
    logic        writes;
    logic        taken;
    @(posedge clk);
    // The slot sampled at this edge now sits in Execute
    if (!lastStall) begin
      expRedirect = lastTaken;
      expTarget   = lastTarget;
    end
    lastStall = stallBit;
    stall <= stallBit;
    if (!stallBit) begin
      pickInstr(pcModel, instr, writes, rd, data, taken, target);
      instrD     <= instr;
      pcD        <= pcModel;
      instrValid <= validBit;
      lastTaken = 1'b0;
      if (killPending) begin
        // Wrong-path slot before fetch resumes at the target
        killPending = 1'b0;
        pcModel     = pendingPc;
      end else if (validBit) begin
        if (writes) begin
          retireQ.push_back({rd, data});
          if (rd != 5'd0) begin
            regModel[rd] = data;
          end
        end
        if (taken) begin
          lastTaken   = 1'b1;
          lastTarget  = target;
          killPending = 1'b1;
          pendingPc   = target;
        end
        pcModel = pcModel + 32'd4;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus and end of run
  //////////////////////////////////////////////////

  initial begin : stimulus
    logic s;
    logic v;
    arstN      <= 1'b0;
    stall      <= 1'b0;
    instrValid <= 1'b0;
    instrD     <= 32'h0000_0013;
    pcD        <= '0;
    lfsr        = lfsrSeed;
    pcModel     = 32'h0000_1000;
    pendingPc   = '0;
    killPending = 1'b0;
    lastStall   = 1'b0;
    lastTaken   = 1'b0;
    lastTarget  = '0;
    expRedirect = 1'b0;
    expTarget   = '0;
    for (int i = 0; i < 32; i++) begin
      regModel[i] = '0;
    end
    repeat (5) @(posedge clk);
    arstN <= 1'b1;
    repeat (3) issueSlot(1'b0, 1'b0);
    // About one stall and one gap in eight slots
    for (int n = 0; n < numSteps; n++) begin
      s = (lfsrBits(3) == 32'd0);
      v = (lfsrBits(3) != 32'd0);
      issueSlot(s, v);
    end
    // Drain for a few pipeline depths at most
    for (int d = 0; d < 8 && retireQ.size() != 0; d++) begin
      issueSlot(1'b0, 1'b0);
    end
    // Room for any retirement the model did not expect
    repeat (4) issueSlot(1'b0, 1'b0);
    $display("Retired %0d instructions", retired);
    if (retireQ.size() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      stopWithFailure("Expected instructions were still waiting to retire");
    end
  end

  initial begin : watchdog
    #(numSteps * 4 * clkPeriod + 2000);
    stopWithFailure("Simulation timed out before the pipeline drained");
  end

  //////////////////////////////////////////////////
  // Monitor and assertions
  //////////////////////////////////////////////////

  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      sinceReset <= 0;
    end else if (sinceReset < 8) begin
      sinceReset <= sinceReset + 1;
    end
  end

  // Take the next expected retirement mid-cycle where Writeback is stable
  always @(negedge clk) begin
    if (arstN && wbValid) begin
      haveExp = (retireQ.size() != 0);
      if (haveExp) begin
        expWb = retireQ.pop_front();
        retired++;
      end
    end
  end

  assert property (@(posedge clk) (!arstN || sinceReset < 3) |-> (!wbValid && !redirect))
    else stopWithFailure("wbValid or redirect was active during or right after reset");

  assert property (@(posedge clk) disable iff (!arstN) stall |-> !wbValid)
    else stopWithFailure("wbValid was high in a stalled cycle");

  assert property (@(posedge clk) disable iff (!arstN) wbValid |-> haveExp)
    else stopWithFailure("An instruction retired that the model never expected");

  assert property (@(posedge clk) disable iff (!arstN) wbValid |-> wbRd == expWb[36:32])
    else reportMismatch("wbRd", 32'($sampled(expWb[36:32])), 32'($sampled(wbRd)));

  assert property (@(posedge clk) disable iff (!arstN) wbValid |-> wbData == expWb[31:0])
    else reportMismatch("wbData", $sampled(expWb[31:0]), $sampled(wbData));

  // Not-taken branches and bubbles must stay quiet
  assert property (@(posedge clk) disable iff (!arstN) redirect == expRedirect)
    else reportMismatch("redirect", 32'($sampled(expRedirect)), 32'($sampled(redirect)));

  assert property (@(posedge clk) disable iff (!arstN) redirect |-> redirectTarget == expTarget)
    else reportMismatch("redirectTarget", $sampled(expTarget), $sampled(redirectTarget));

  initial begin
    haveExp = 1'b0;
    expWb   = '0;
    retired = 0;
  end

endmodule

`default_nettype wire

// ==== build.f ====
ieuCfgPkg.sv
ieuOpPkg.sv
regFile.sv
immExtend.sv
intAlu.sv
ieuController.sv
hazardUnit.sv
ieuDatapath.sv
intExecUnit.sv
ieuTb.sv

// ==== Makefile ====
# Verilator flow for the integer execution unit testbench

TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= ieuTb
FILELIST ?= build.f
OBJDIR   ?= obj_dir
LOG      ?= sim.log

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(wildcard *.sv)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
